// ==== rob_core.f ====
+incdir+source
source/rob_pkg.sv
source/rob_pointer_counter.sv
source/rob_storage.sv
source/arch_regfile.sv
source/regfile_wb_fsm.sv
source/rob_core.sv
bench/rob_core_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build rob_core_tb with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -j 0 --top-module rob_core_tb -Mdir obj_dir -f rob_core.f
	./obj_dir/Vrob_core_tb | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/rob_trace.txt ====
# ALLOC <dest hex> <tag hex> | FILL <lane A/B> <slot hex> <data hex> | IDLE <cycles decimal>
# READ <register hex> <expected data hex> | READY <expected alloc_ready>
# After reset
READY 1
READ 00 00000000
READ 05 00000000
READ 1f 00000000
# In-order commit, slot 0 blocks the younger slots
ALLOC 05 0
ALLOC 06 1
ALLOC 07 2
FILL A 2 00000222
FILL A 1 00000111
IDLE 2
READ 05 00000000
READ 06 00000000
READ 07 00000000
FILL B 0 00000100
IDLE 3
READ 05 00000100
READ 06 00000111
READ 07 00000222
# Dual commit to one register, the younger entry wins
ALLOC 08 3
ALLOC 08 4
FILL A 3 0000aaaa
FILL B 4 0000bbbb
IDLE 3
READ 08 0000bbbb
ALLOC 09 5
ALLOC 09 6
FILL A 6 00006666
FILL B 5 00005555
IDLE 3
READ 09 00006666
# Register x0 stays zero
ALLOC 00 7
ALLOC 0a 8
FILL A 7 deadbeef
FILL B 8 0000000a
IDLE 3
READ 00 00000000
READ 0a 0000000a
# Full buffer, ignored request, then wrap
ALLOC 10 9
ALLOC 11 a
ALLOC 12 b
ALLOC 13 c
ALLOC 14 d
ALLOC 15 e
ALLOC 16 f
ALLOC 17 0
ALLOC 18 1
ALLOC 19 2
ALLOC 1a 3
ALLOC 1b 4
ALLOC 1c 5
ALLOC 1d 6
ALLOC 1e 7
ALLOC 1f 8
READY 0
ALLOC 01 9
READY 0
FILL A 9 00001010
FILL B a 00001011
FILL A b 00001012
FILL B c 00001013
FILL A d 00001014
FILL B e 00001015
FILL A f 00001016
FILL B 0 00001017
FILL A 1 00001018
FILL B 2 00001019
FILL A 3 0000101a
FILL B 4 0000101b
FILL A 5 0000101c
FILL B 6 0000101d
FILL A 7 0000101e
FILL B 8 0000101f
IDLE 3
READY 1
ALLOC 01 9
FILL A 9 00000001
IDLE 3
READ 10 00001010
READ 17 00001017
READ 1f 0000101f
READ 01 00000001

// ==== bench/rob_core_tb.sv ====
//--------------------------------------------------------------------------
// ROB commit back end testbench
// Replays a trace of allocations, fills and Wishbone reads with checks
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rob_core_tb;
  import rob_pkg::*;

  logic          clk;
  logic          reset;
  dispatch_req_t dispatch;
  logic          alloc_ready;
  rob_slot_t     alloc_tag;
  fill_lane_t    fill_a;
  fill_lane_t    fill_b;
  logic          wb_cyc;
  logic          wb_stb;
  reg_addr_t     wb_adr;
  logic          wb_ack;
  data_word_t    wb_dat;

  int checks;
  int mismatches;
  int failures;

  rob_core u_dut (
    .clk         (clk),
    .reset       (reset),
    .dispatch    (dispatch),
    .alloc_ready (alloc_ready),
    .alloc_tag   (alloc_tag),
    .fill_a      (fill_a),
    .fill_b      (fill_b),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_adr      (wb_adr),
    .wb_ack      (wb_ack),
    .wb_dat      (wb_dat)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------

  task automatic compare_data(input string name, input data_word_t expected,
                              input data_word_t actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_tag(input string name, input rob_slot_t expected,
                             input rob_slot_t actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("ERR time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
    end
  endtask

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------

  // One-shot inputs drop at the falling edge after each rising edge
  task automatic step_cycle();
    @(posedge clk);
    @(negedge clk);
    dispatch.valid = 1'b0;
    fill_a.valid   = 1'b0;
    fill_b.valid   = 1'b0;
  endtask

  task automatic request_alloc(input reg_addr_t dest, input rob_slot_t expected_tag);
    compare_tag("alloc_tag", expected_tag, alloc_tag);
    dispatch.valid = 1'b1;
    dispatch.dest  = dest;
    step_cycle();
  endtask

  // A busy lane forces an edge before its next result
  task automatic stage_fill(input string lane, input rob_slot_t slot, input data_word_t data);
    if (lane == "A") begin
      if (fill_a.valid) begin
        step_cycle();
      end
      fill_a.valid = 1'b1;
      fill_a.slot  = slot;
      fill_a.data  = data;
    end else if (lane == "B") begin
      if (fill_b.valid) begin
        step_cycle();
      end
      fill_b.valid = 1'b1;
      fill_b.slot  = slot;
      fill_b.data  = data;
    end else begin
      failures++;
      $display("Unknown fill lane %s at time %0t", lane, $time);
    end
  endtask

  task automatic wb_read(input reg_addr_t addr, input data_word_t expected);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    compare_flag("wb_ack", 1'b0, wb_ack);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_adr = addr;
    while (!acked && waited < 20) begin
      step_cycle();
      waited++;
      acked = wb_ack;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    if (acked) begin
      compare_data($sformatf("wb_dat[x%0d]", addr), expected, wb_dat);
    end else begin
      failures++;
      $display("No ack within 20 cycles for the read of register x%0d", addr);
    end
    // No further ack once strobe is low
    repeat (2) begin
      step_cycle();
      compare_flag("wb_ack", 1'b0, wb_ack);
    end
  endtask

  //--------------------------------------------------------------------------
  // Trace replay
  //--------------------------------------------------------------------------

  task automatic report_malformed_line(input int line_no, input int found, input int wanted);
    failures++;
    $display("Trace line %0d has %0d fields where %0d are needed", line_no, found, wanted);
  endtask

  task automatic run_line(input string line, input int line_no);
    string       word;
    string       lane;
    logic [31:0] val_a;
    logic [31:0] val_b;
    int          cycles;
    int          n;
    n = $sscanf(line, "%s", word);
    if (word == "ALLOC") begin
      n = $sscanf(line, "%s %h %h", word, val_a, val_b);
      if (n == 3) begin
        request_alloc(reg_addr_t'(val_a), rob_slot_t'(val_b));
      end else begin
        report_malformed_line(line_no, n, 3);
      end
    end else if (word == "FILL") begin
      n = $sscanf(line, "%s %s %h %h", word, lane, val_a, val_b);
      if (n == 4) begin
        stage_fill(lane, rob_slot_t'(val_a), val_b);
      end else begin
        report_malformed_line(line_no, n, 4);
      end
    end else if (word == "IDLE") begin
      n = $sscanf(line, "%s %d", word, cycles);
      if (n == 2) begin
        repeat (cycles) step_cycle();
      end else begin
        report_malformed_line(line_no, n, 2);
      end
    end else if (word == "READ") begin
      n = $sscanf(line, "%s %h %h", word, val_a, val_b);
      if (n == 3) begin
        wb_read(reg_addr_t'(val_a), val_b);
      end else begin
        report_malformed_line(line_no, n, 3);
      end
    end else if (word == "READY") begin
      n = $sscanf(line, "%s %h", word, val_a);
      if (n == 2) begin
        compare_flag("alloc_ready", val_a[0], alloc_ready);
      end else begin
        report_malformed_line(line_no, n, 2);
      end
    end else begin
      failures++;
      $display("Unknown trace operation %s on line %0d", word, line_no);
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    line_no;
    string line;
    string word;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    line_no    = 0;
    reset      = 1'b1;
    dispatch   = '0;
    fill_a     = '0;
    fill_b     = '0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_adr     = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    fd = $fopen("bench/rob_trace.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("Could not open the trace file bench/rob_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        line_no++;
        if (n > 0 && $sscanf(line, "%s", word) == 1) begin
          // Lines starting with # are comments
          if (word.getc(0) != "#") begin
            run_line(line, line_no);
          end
        end
      end
      $fclose(fd);
    end
    step_cycle();

    if (checks == 0) begin
      failures++;
      $display("No checks were run");
    end
    $display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/rob_core.sv ====
//--------------------------------------------------------------------------
// ROB commit back end
// Reorder buffer, in-order dual commit and register file read over Wishbone
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rob_core (
  input  logic                   clk,
  input  logic                   reset,
  input  rob_pkg::dispatch_req_t dispatch,
  output logic                   alloc_ready,
  output rob_pkg::rob_slot_t     alloc_tag,
  input  rob_pkg::fill_lane_t    fill_a,
  input  rob_pkg::fill_lane_t    fill_b,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  rob_pkg::reg_addr_t     wb_adr,
  output logic                   wb_ack,
  output rob_pkg::data_word_t    wb_dat
);
  import rob_pkg::*;

  rob_slot_t    head;
  logic         head_done;
  logic         next_done;
  reg_addr_t    head_dest;
  reg_addr_t    next_dest;
  data_word_t   head_data;
  data_word_t   next_data;
  commit_port_t commit_0;
  commit_port_t commit_1;
  rob_count_t   retire_count;
  logic         alloc_en;
  reg_addr_t    rf_raddr;
  data_word_t   rf_rdata;

  // Glue between counter and storage
  assign alloc_en     = dispatch.valid && alloc_ready;
  assign retire_count = rob_count_t'(commit_0.wen) + rob_count_t'(commit_1.wen);

  rob_pointer_counter u_counter (
    .clk            (clk),
    .reset          (reset),
    .dispatch_valid (dispatch.valid),
    .head_done      (head_done),
    .next_done      (next_done),
    .head_dest      (head_dest),
    .next_dest      (next_dest),
    .head_data      (head_data),
    .next_data      (next_data),
    .head           (head),
    .tail           (alloc_tag),
    .alloc_ready    (alloc_ready),
    .commit_0       (commit_0),
    .commit_1       (commit_1)
  );

  rob_storage u_storage (
    .clk          (clk),
    .reset        (reset),
    .alloc_en     (alloc_en),
    .tail         (alloc_tag),
    .alloc_dest   (dispatch.dest),
    .fill_a       (fill_a),
    .fill_b       (fill_b),
    .head         (head),
    .retire_count (retire_count),
    .head_done    (head_done),
    .next_done    (next_done),
    .head_dest    (head_dest),
    .next_dest    (next_dest),
    .head_data    (head_data),
    .next_data    (next_data)
  );

  arch_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .commit_0 (commit_0),
    .commit_1 (commit_1),
    .raddr    (rf_raddr),
    .rdata    (rf_rdata)
  );

  regfile_wb_fsm u_wb_fsm (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .rf_rdata (rf_rdata),
    .rf_raddr (rf_raddr),
    .wb_ack   (wb_ack),
    .wb_dat   (wb_dat)
  );

endmodule

// ==== source/regfile_wb_fsm.sv ====
//--------------------------------------------------------------------------
// Register file Wishbone read slave
// Classic cycle, one ack per request, waits for strobe release
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module regfile_wb_fsm (
  input  logic                clk,
  input  logic                reset,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  rob_pkg::reg_addr_t  wb_adr,
  input  rob_pkg::data_word_t rf_rdata,
  output rob_pkg::reg_addr_t  rf_raddr,
  output logic                wb_ack,
  output rob_pkg::data_word_t wb_dat
);
  import rob_pkg::*;

  wb_state_t state;

  // Read address follows the bus directly
  assign rf_raddr = wb_adr;
  assign wb_ack   = (state == WB_ACK);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= WB_IDLE;
    end else begin
      case (state)
        WB_IDLE: if (wb_cyc && wb_stb) state <= WB_ACK;
        WB_ACK:  state <= WB_HOLD;
        WB_HOLD: if (!wb_stb) state <= WB_IDLE;
        default: state <= WB_IDLE;
      endcase
    end
  end

  // Capture on the accepting edge, held through the ack cycle
  always_ff @(posedge clk) begin
    if ((state == WB_IDLE) && wb_cyc && wb_stb) begin
      wb_dat <= rf_rdata;
    end
  end

endmodule

// ==== source/arch_regfile.sv ====
//--------------------------------------------------------------------------
// Architectural register file
// Two ordered commit write ports, one read port, x0 hard-wired to zero
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "rob_settings.svh"

module arch_regfile (
  input  logic                  clk,
  input  logic                  reset,
  input  rob_pkg::commit_port_t commit_0,
  input  rob_pkg::commit_port_t commit_1,
  input  rob_pkg::reg_addr_t    raddr,
  output rob_pkg::data_word_t   rdata
);
  import rob_pkg::*;

  data_word_t regs [`REG_COUNT];

  assign rdata = regs[raddr];

  // commit_1 is the younger entry, so its write comes last
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit_0.wen && (commit_0.waddr != '0)) begin
        regs[commit_0.waddr] <= commit_0.data;
      end
      if (commit_1.wen && (commit_1.waddr != '0)) begin
        regs[commit_1.waddr] <= commit_1.data;
      end
    end
  end

endmodule

// ==== source/rob_storage.sv ====
//--------------------------------------------------------------------------
// ROB slot storage
// Data, destination and done bit per slot, two fill ports, head reads
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_storage (
  input  logic                clk,
  input  logic                reset,
  input  logic                alloc_en,
  input  rob_pkg::rob_slot_t  tail,
  input  rob_pkg::reg_addr_t  alloc_dest,
  input  rob_pkg::fill_lane_t fill_a,
  input  rob_pkg::fill_lane_t fill_b,
  input  rob_pkg::rob_slot_t  head,
  input  rob_pkg::rob_count_t retire_count,
  output logic                head_done,
  output logic                next_done,
  output rob_pkg::reg_addr_t  head_dest,
  output rob_pkg::reg_addr_t  next_dest,
  output rob_pkg::data_word_t head_data,
  output rob_pkg::data_word_t next_data
);
  import rob_pkg::*;

  data_word_t             slot_data [`ROB_DEPTH];
  reg_addr_t              slot_dest [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0]  slot_done;
  rob_slot_t              next;

  //--------------------------------------------------------------------------
  // Head reads
  //--------------------------------------------------------------------------

  assign next      = head + rob_slot_t'(1);
  assign head_done = slot_done[head];
  assign next_done = slot_done[next];
  assign head_dest = slot_dest[head];
  assign next_dest = slot_dest[next];
  assign head_data = slot_data[head];
  assign next_data = slot_data[next];

  //--------------------------------------------------------------------------
  // Done bits
  //--------------------------------------------------------------------------

  // Later writes take priority: retire, then allocate, then fill
  always_ff @(posedge clk) begin
    if (reset) begin
      slot_done <= '0;
    end else begin
      if (retire_count != '0) begin
        slot_done[head] <= 1'b0;
      end
      if (retire_count == rob_count_t'(2)) begin
        slot_done[next] <= 1'b0;
      end
      if (alloc_en) begin
        slot_done[tail] <= 1'b0;
      end
      if (fill_a.valid) begin
        slot_done[fill_a.slot] <= 1'b1;
      end
      if (fill_b.valid) begin
        slot_done[fill_b.slot] <= 1'b1;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (alloc_en) begin
      slot_dest[tail] <= alloc_dest;
    end
    if (fill_a.valid) begin
      slot_data[fill_a.slot] <= fill_a.data;
    end
    if (fill_b.valid) begin
      slot_data[fill_b.slot] <= fill_b.data;
    end
  end

endmodule

// ==== source/rob_pointer_counter.sv ====
//--------------------------------------------------------------------------
// ROB pointer counter
// Head, tail and occupancy, plus the per-cycle retire decision
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_pointer_counter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  logic                  head_done,
  input  logic                  next_done,
  input  rob_pkg::reg_addr_t    head_dest,
  input  rob_pkg::reg_addr_t    next_dest,
  input  rob_pkg::data_word_t   head_data,
  input  rob_pkg::data_word_t   next_data,
  output rob_pkg::rob_slot_t    head,
  output rob_pkg::rob_slot_t    tail,
  output logic                  alloc_ready,
  output rob_pkg::commit_port_t commit_0,
  output rob_pkg::commit_port_t commit_1
);
  import rob_pkg::*;

  rob_count_t count;
  rob_count_t retire_n;
  logic       alloc_fire;
  logic       head_ok;
  logic       pair_ok;

  // Back-pressure once every slot is taken
  assign alloc_ready = (count != rob_count_t'(`ROB_DEPTH));
  assign alloc_fire  = dispatch_valid && alloc_ready;

  // Only occupied entries may retire, stale done bits are ignored
  assign head_ok = (count != '0) && head_done;
  assign pair_ok = head_ok && (count > rob_count_t'(1)) && next_done;

  always_comb begin
    retire_n       = pair_ok ? rob_count_t'(2) : (head_ok ? rob_count_t'(1) : '0);
    commit_0.wen   = head_ok;
    commit_0.waddr = head_dest;
    commit_0.data  = head_data;
    commit_1.wen   = pair_ok;
    commit_1.waddr = next_dest;
    commit_1.data  = next_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc_fire) begin
        tail <= tail + rob_slot_t'(1);
      end
      // Pointers wrap on their own width
      head  <= head + rob_slot_t'(retire_n);
      count <= count + rob_count_t'(alloc_fire) - retire_n;
    end
  end

endmodule

// ==== source/rob_pkg.sv ====
//--------------------------------------------------------------------------
// ROB back end types
// Width typedefs, lane and port structs, Wishbone FSM states
//--------------------------------------------------------------------------

`include "rob_settings.svh"

package rob_pkg;

  // Plain vectors with a meaning
  typedef logic [`DATA_WIDTH-1:0]    data_word_t;
  typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [`ROB_SLOT_BITS-1:0] rob_slot_t;

  // One extra bit so a full buffer can be told from an empty one
  typedef logic [`ROB_SLOT_BITS:0]   rob_count_t;

  // Allocation request from dispatch
  typedef struct packed {
    logic      valid;
    reg_addr_t dest;
  } dispatch_req_t;

  // Result from one execution lane
  typedef struct packed {
    logic       valid;
    rob_slot_t  slot;
    data_word_t data;
  } fill_lane_t;

  // Register file write from commit
  typedef struct packed {
    logic       wen;
    reg_addr_t  waddr;
    data_word_t data;
  } commit_port_t;

  typedef enum logic [1:0] {
    WB_IDLE,
    WB_ACK,
    WB_HOLD
  } wb_state_t;

endpackage

// ==== source/rob_settings.svh ====
//--------------------------------------------------------------------------
// ROB back end sizing
// Depth of the reorder buffer, register count and data width
//--------------------------------------------------------------------------

`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Reorder buffer
`define ROB_DEPTH     16
`define ROB_SLOT_BITS 4

// Architectural register file
`define REG_COUNT     32
`define REG_ADDR_BITS 5

`define DATA_WIDTH    32

`endif
